//--- cache_cfg.svh
// geometry macros of the two-way cache
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// byte offset inside a 32-byte line
`define CACHE_OFFSET_BITS 5

// set index
`define CACHE_INDEX_BITS 3
`define CACHE_NUM_SETS 8

// one line, one enable per byte
`define CACHE_LINE_BITS 256
`define CACHE_MASK_BITS 32

`endif

//--- rv32i_types.sv
// shared types for the two-way cache, its CPU port and its memory port
`include "cache_cfg.svh"

package rv32i_types;

    typedef logic [31:0] rv32i_word;
    typedef logic [31-`CACHE_OFFSET_BITS-`CACHE_INDEX_BITS:0] cache_tag_t;
    typedef logic [`CACHE_INDEX_BITS-1:0] cache_index_t;
    typedef logic [`CACHE_LINE_BITS-1:0] cache_line_t;
    typedef logic [`CACHE_MASK_BITS-1:0] cache_mask_t;

    typedef struct packed {
        logic        read;
        logic        write;
        rv32i_word   address;
        cache_line_t wdata;
        cache_mask_t byte_enable;
    } cpu_req_t;

    typedef struct packed {
        logic        read;
        logic        write;
        rv32i_word   address;
        cache_line_t wdata;
    } pmem_req_t;

    // control strobes from the FSM to the datapath
    typedef struct packed {
        logic set_dirty;
        logic reset_dirty;
        logic set_valid;
        logic load_tag;
        logic set_lru;
        logic data_read;
        logic load_data;
        logic pmem_write;
    } cache_ctrl_t;

    typedef struct packed {
        logic hit;
        logic dirty;   // dirty bit of the lru victim
    } cache_status_t;

endpackage

//--- cache_array.sv
// per-set register file with registered read, one entry of any type per set
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_array #(
    parameter type entry_t = logic
)
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      read,
    input  logic                      load,
    input  rv32i_types::cache_index_t index,
    input  entry_t                    datain,
    output entry_t                    dataout
);

    entry_t mem [`CACHE_NUM_SETS];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < `CACHE_NUM_SETS; i++)
            begin
                mem[i] <= '0;
            end
            dataout <= '0;
        end
        else
        begin
            if (load)
            begin
                mem[index] <= datain;
            end
            // new value shows through on a same-cycle read
            if (read)
            begin
                dataout <= load ? datain : mem[index];
            end
        end
    end

endmodule

//--- cache_data_array.sv
// per-set line storage with byte-lane write enables and registered read
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_data_array
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      read,
    input  rv32i_types::cache_mask_t  write_en,
    input  rv32i_types::cache_index_t index,
    input  rv32i_types::cache_line_t  datain,
    output rv32i_types::cache_line_t  dataout
);

    rv32i_types::cache_line_t mem [`CACHE_NUM_SETS];
    rv32i_types::cache_line_t merged;

    // stored line with the enabled lanes replaced
    always_comb
    begin
        merged = mem[index];
        for (int b = 0; b < `CACHE_MASK_BITS; b++)
        begin
            if (write_en[b])
            begin
                merged[8*b +: 8] = datain[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (|write_en)
        begin
            mem[index] <= merged;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            dataout <= '0;
        end
        else if (read)
        begin
            dataout <= merged;   // write-through on same index
        end
    end

endmodule

//--- cache_datapath.sv
// datapath of the two-way cache with tag compare, way select and the set arrays
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_datapath
(
    input  logic                       clk,
    input  logic                       rst,
    input  rv32i_types::cache_ctrl_t   ctrl,
    input  rv32i_types::cpu_req_t      req,
    input  rv32i_types::cache_line_t   pmem_rdata,
    output rv32i_types::cache_status_t status,
    output rv32i_types::cache_line_t   mem_rdata,
    output rv32i_types::rv32i_word     pmem_address,
    output rv32i_types::cache_line_t   pmem_wdata
);

    localparam int TAG_LSB = `CACHE_OFFSET_BITS + `CACHE_INDEX_BITS;

    rv32i_types::cache_tag_t   tag;
    rv32i_types::cache_index_t idx;
    rv32i_types::cache_index_t idx_q;   // index of the last array read

    rv32i_types::cache_tag_t  tag_q [2];
    rv32i_types::cache_line_t line_q [2];
    rv32i_types::cache_mask_t line_we [2];
    logic                     valid_q [2];
    logic                     dirty_q [2];
    logic                     tag_ld [2];
    logic                     valid_ld [2];
    logic                     dirty_ld [2];
    logic [1:0]               hit_way;
    logic [1:0]               way_sel;
    logic                     victim;
    rv32i_types::cache_line_t line_in;

    assign tag = req.address[31:TAG_LSB];
    assign idx = req.address[TAG_LSB-1:`CACHE_OFFSET_BITS];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            idx_q <= '0;
        end
        else if (ctrl.data_read)
        begin
            idx_q <= idx;
        end
    end

    // write merge takes cpu data, a fill takes the whole memory line
    assign line_in = ctrl.set_dirty ? req.wdata : pmem_rdata;

    always_comb
    begin
        for (int w = 0; w < 2; w++)
        begin
            hit_way[w]  = valid_q[w] && (tag_q[w] == tag) && (idx == idx_q);
            way_sel[w]  = (victim == 1'(w));
            tag_ld[w]   = ctrl.load_tag && way_sel[w];
            valid_ld[w] = ctrl.set_valid && way_sel[w];
            dirty_ld[w] = (ctrl.set_dirty && hit_way[w]) || (ctrl.reset_dirty && way_sel[w]);
            line_we[w]  = '0;
            if (ctrl.load_data && ctrl.set_dirty && hit_way[w])
            begin
                line_we[w] = req.byte_enable;
            end
            else if (ctrl.load_data && !ctrl.set_dirty && way_sel[w])
            begin
                line_we[w] = '1;
            end
        end
    end

    for (genvar w = 0; w < 2; w++)
    begin : g_way
        cache_array #(.entry_t(rv32i_types::cache_tag_t)) u_tag (
            .clk     (clk),
            .rst     (rst),
            .read    (ctrl.data_read),
            .load    (tag_ld[w]),
            .index   (idx),
            .datain  (tag),
            .dataout (tag_q[w])
        );

        cache_array #(.entry_t(logic)) u_valid (
            .clk     (clk),
            .rst     (rst),
            .read    (ctrl.data_read),
            .load    (valid_ld[w]),
            .index   (idx),
            .datain  (1'b1),
            .dataout (valid_q[w])
        );

        cache_array #(.entry_t(logic)) u_dirty (
            .clk     (clk),
            .rst     (rst),
            .read    (ctrl.data_read),
            .load    (dirty_ld[w]),
            .index   (idx),
            .datain  (ctrl.set_dirty),
            .dataout (dirty_q[w])
        );

        cache_data_array u_line (
            .clk      (clk),
            .rst      (rst),
            .read     (ctrl.data_read),
            .write_en (line_we[w]),
            .index    (idx),
            .datain   (line_in),
            .dataout  (line_q[w])
        );
    end

    // lru bit names the victim way, a hit on way 0 makes way 1 the victim
    cache_array #(.entry_t(logic)) u_lru (
        .clk     (clk),
        .rst     (rst),
        .read    (ctrl.data_read),
        .load    (ctrl.set_lru),
        .index   (idx),
        .datain  (hit_way[0]),
        .dataout (victim)
    );

    assign status = '{hit: |hit_way, dirty: dirty_q[victim]};
    assign mem_rdata  = hit_way[1] ? line_q[1] : line_q[0];
    assign pmem_wdata = line_q[victim];

    // write-back goes to the victim's line, a fill to the requested one
    assign pmem_address = ctrl.pmem_write ?
        {tag_q[victim], idx, {`CACHE_OFFSET_BITS{1'b0}}} :
        {req.address[31:`CACHE_OFFSET_BITS], {`CACHE_OFFSET_BITS{1'b0}}};

    // a tag may live in one way of a set only
    a_one_way_hit: assert property (@(posedge clk) disable iff (rst) !(hit_way[0] && hit_way[1]));

endmodule

//--- cache_control.sv
// cache FSM sequencing compare, write-back, fill and response
`timescale 1ns/1ps

module cache_control
(
    input  logic                       clk,
    input  logic                       rst,
    input  rv32i_types::cpu_req_t      req,
    input  rv32i_types::cache_status_t status,
    input  logic                       pmem_resp,
    output rv32i_types::cache_ctrl_t   ctrl,
    output logic                       mem_resp,
    output logic                       pmem_read,
    output logic                       pmem_write
);

    typedef enum logic [2:0] {IDLE, COMPARE, WRITEBACK, FILL, RESP} state_t;

    state_t state;
    state_t state_next;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= IDLE;
        end
        else
        begin
            state <= state_next;
        end
    end

    always_comb
    begin
        state_next = state;
        ctrl       = '0;
        mem_resp   = 1'b0;
        pmem_read  = 1'b0;
        pmem_write = 1'b0;
        unique case (state)
            IDLE:
            begin
                if (req.read || req.write)
                begin
                    ctrl.data_read = 1'b1;   // arrays valid next cycle
                    state_next     = COMPARE;
                end
            end
            COMPARE:
            begin
                if (status.hit)
                begin
                    ctrl.set_lru   = 1'b1;
                    ctrl.data_read = 1'b1;   // refresh outputs for RESP
                    if (req.write)
                    begin
                        ctrl.set_dirty = 1'b1;
                        ctrl.load_data = 1'b1;
                    end
                    state_next = RESP;
                end
                else
                begin
                    state_next = status.dirty ? WRITEBACK : FILL;
                end
            end
            WRITEBACK:
            begin
                pmem_write      = 1'b1;
                ctrl.pmem_write = 1'b1;
                if (pmem_resp)
                begin
                    state_next = FILL;
                end
            end
            FILL:
            begin
                pmem_read = 1'b1;
                if (pmem_resp)
                begin
                    // install line in victim way, clean and valid
                    ctrl.load_data   = 1'b1;
                    ctrl.load_tag    = 1'b1;
                    ctrl.set_valid   = 1'b1;
                    ctrl.reset_dirty = 1'b1;
                    ctrl.data_read   = 1'b1;
                    state_next       = COMPARE;
                end
            end
            RESP:
            begin
                mem_resp   = 1'b1;
                state_next = IDLE;
            end
            default:
            begin
                state_next = IDLE;
            end
        endcase
    end

    a_pmem_excl: assert property (@(posedge clk) disable iff (rst) !(pmem_read && pmem_write));
    a_resp_pulse: assert property (@(posedge clk) disable iff (rst) mem_resp |=> !mem_resp);

endmodule

//--- cache.sv
// two-way write-back cache top joining the FSM and the datapath
`timescale 1ns/1ps

module cache
(
    input  logic                     clk,
    input  logic                     rst,
    input  rv32i_types::cpu_req_t    cpu_req,
    input  rv32i_types::cache_line_t pmem_rdata,
    input  logic                     pmem_resp,
    output rv32i_types::cache_line_t mem_rdata,
    output logic                     mem_resp,
    output rv32i_types::pmem_req_t   pmem_req
);

    rv32i_types::cache_ctrl_t   ctrl;
    rv32i_types::cache_status_t status;
    rv32i_types::rv32i_word     pmem_address;
    rv32i_types::cache_line_t   pmem_wdata;
    logic                       pmem_read;
    logic                       pmem_write;

    cache_control u_control (
        .clk        (clk),
        .rst        (rst),
        .req        (cpu_req),
        .status     (status),
        .pmem_resp  (pmem_resp),
        .ctrl       (ctrl),
        .mem_resp   (mem_resp),
        .pmem_read  (pmem_read),
        .pmem_write (pmem_write)
    );

    cache_datapath u_datapath (
        .clk          (clk),
        .rst          (rst),
        .ctrl         (ctrl),
        .req          (cpu_req),
        .pmem_rdata   (pmem_rdata),
        .status       (status),
        .mem_rdata    (mem_rdata),
        .pmem_address (pmem_address),
        .pmem_wdata   (pmem_wdata)
    );

    assign pmem_req = '{read: pmem_read, write: pmem_write,
                        address: pmem_address, wdata: pmem_wdata};

endmodule

//--- tb_mem_model.sv
// behavioral line memory for the cache testbench with fixed response delay and access counts
`timescale 1ns/1ps
`include "cache_cfg.svh"

module tb_mem_model #(
    parameter int          LINES = 64,
    parameter int          DELAY = 3,
    parameter logic [31:0] SEED  = 32'hefd
)
(
    input  logic                     clk,
    input  rv32i_types::pmem_req_t   pmem_req,
    output rv32i_types::cache_line_t pmem_rdata,
    output logic                     pmem_resp,
    output int                       reads,
    output int                       writes
);

    localparam int LINE_BITS = $clog2(LINES);

    rv32i_types::cache_line_t mem [LINES];
    int wait_cnt;

    initial
    begin
        int seed;
        seed = SEED;
        for (int i = 0; i < LINES; i++)
        begin
            for (int j = 0; j < 8; j++)
            begin
                mem[i][32*j +: 32] = $random(seed) ^ (i * 8 + j);   // word address mixed in
            end
        end
        pmem_rdata = '0;
        pmem_resp  = 1'b0;
        reads      = 0;
        writes     = 0;
        wait_cnt   = 0;
    end

    // driven on the falling edge, the cache samples on the rising one
    always @(negedge clk)
    begin
        if (pmem_resp)
        begin
            pmem_resp = 1'b0;   // one-cycle pulse
            wait_cnt  = 0;
        end
        else if (pmem_req.read || pmem_req.write)
        begin
            if (wait_cnt < DELAY)
            begin
                wait_cnt = wait_cnt + 1;
            end
            else if (pmem_req.write)
            begin
                mem[pmem_req.address[`CACHE_OFFSET_BITS +: LINE_BITS]] = pmem_req.wdata;
                writes    = writes + 1;
                pmem_resp = 1'b1;
            end
            else
            begin
                pmem_rdata = mem[pmem_req.address[`CACHE_OFFSET_BITS +: LINE_BITS]];
                reads      = reads + 1;
                pmem_resp  = 1'b1;
            end
        end
    end

endmodule

//--- tb_cache.sv
// testbench for the two-way cache with a shadow line memory and a response checker
`timescale 1ns/1ps
`include "cache_cfg.svh"

module tb_cache;

    localparam int          MEM_LINES = 64;
    localparam int          MEM_DELAY = 3;
    localparam int          LINE_BITS = $clog2(MEM_LINES);
    localparam int          TIMEOUT   = 200;
    localparam logic [31:0] MEM_SEED  = 32'hefd;

    logic                     clk;
    logic                     rst;
    rv32i_types::cpu_req_t    cpu_req;
    rv32i_types::cache_line_t mem_rdata;
    logic                     mem_resp;
    rv32i_types::pmem_req_t   pmem_req;
    rv32i_types::cache_line_t pmem_rdata;
    logic                     pmem_resp;
    int                       reads;
    int                       writes;

    rv32i_types::cache_line_t shadow [MEM_LINES];
    rv32i_types::cache_line_t exp_lines [$];
    rv32i_types::rv32i_word   exp_addrs [$];
    int                       seed;
    int                       line_errs = 0;
    int                       count_errs = 0;
    int                       proto_errs = 0;

    cache u_cache (
        .clk        (clk),
        .rst        (rst),
        .cpu_req    (cpu_req),
        .pmem_rdata (pmem_rdata),
        .pmem_resp  (pmem_resp),
        .mem_rdata  (mem_rdata),
        .mem_resp   (mem_resp),
        .pmem_req   (pmem_req)
    );

    tb_mem_model #(.LINES(MEM_LINES), .DELAY(MEM_DELAY), .SEED(MEM_SEED)) u_mem (
        .clk        (clk),
        .pmem_req   (pmem_req),
        .pmem_rdata (pmem_rdata),
        .pmem_resp  (pmem_resp),
        .reads      (reads),
        .writes     (writes)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic check_line(input rv32i_types::cache_line_t got,
                              input rv32i_types::cache_line_t exp, input string what);
        if (got !== exp)
        begin
            line_errs++;
            $display("ERR %0t: %s returned %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp)
        begin
            count_errs++;
            $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // shadow memory that applies a write by byte enable and returns the line
    function automatic rv32i_types::cache_line_t expected_line(
        input rv32i_types::rv32i_word addr, input logic wr,
        input rv32i_types::cache_line_t wdata, input rv32i_types::cache_mask_t be);
        int n;
        n = int'(addr[`CACHE_OFFSET_BITS +: LINE_BITS]);
        if (wr)
        begin
            for (int b = 0; b < `CACHE_MASK_BITS; b++)
            begin
                if (be[b])
                begin
                    shadow[n][8*b +: 8] = wdata[8*b +: 8];
                end
            end
        end
        return shadow[n];
    endfunction

    function automatic rv32i_types::rv32i_word line_addr(input int tag, input int set);
        return rv32i_types::rv32i_word'((tag << (`CACHE_OFFSET_BITS + `CACHE_INDEX_BITS))
                                        | (set << `CACHE_OFFSET_BITS));
    endfunction

    task automatic random_line(output rv32i_types::cache_line_t line);
        for (int j = 0; j < 8; j++)
        begin
            line[32*j +: 32] = $random(seed);
        end
    endtask

    // one request held until mem_resp, cycles counts the falling edges waited
    task automatic access(input logic wr, input rv32i_types::rv32i_word addr,
                          input rv32i_types::cache_line_t wdata,
                          input rv32i_types::cache_mask_t be, output int cycles);
        rv32i_types::cache_line_t exp;
        exp = expected_line(addr, wr, wdata, be);
        @(negedge clk);
        cpu_req = '{read: !wr, write: wr, address: addr, wdata: wdata, byte_enable: be};
        exp_lines.push_back(exp);
        exp_addrs.push_back(addr);
        @(negedge clk);
        cycles = 1;
        while (!mem_resp && cycles < TIMEOUT)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!mem_resp)
        begin
            $display("cache response never came for address %h", addr);
            $display("Something failed");
            $finish;
        end
    endtask

    always @(negedge clk)
    begin
        if (!rst && mem_resp)
        begin
            if (exp_lines.size() == 0)
            begin
                proto_errs++;
                $display("mem_resp came at %0t with no request pending", $time);
            end
            else
            begin
                check_line(mem_rdata, exp_lines.pop_front(),
                           $sformatf("read of line %h", exp_addrs.pop_front()));
            end
        end
    end

    initial
    begin
        int cycles;
        int r0;
        int w0;
        int mseed;
        rv32i_types::cache_line_t wdata;
        rv32i_types::cache_mask_t be;
        seed    = 32'hefd;
        mseed   = MEM_SEED;
        rst     = 1'b1;
        cpu_req = '0;
        for (int i = 0; i < MEM_LINES; i++)
        begin
            for (int j = 0; j < 8; j++)
            begin
                shadow[i][32*j +: 32] = $random(mseed) ^ (i * 8 + j);
            end
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_count(int'({mem_resp, pmem_req.read, pmem_req.write}), 0, "handshake after reset");

        // cold miss, then a hit on the same line
        access(1'b0, line_addr(1, 1), '0, '0, cycles);
        check_count(reads, 1, "pmem reads after cold miss");
        access(1'b0, line_addr(1, 1), '0, '0, cycles);
        check_count(cycles, 2, "hit latency");
        check_count(reads, 1, "pmem reads after hit");

        random_line(wdata);
        be = $random(seed);
        access(1'b1, line_addr(1, 1), wdata, be, cycles);
        access(1'b0, line_addr(1, 1), '0, '0, cycles);
        check_count(reads, 1, "pmem reads after write hit");

        // in set 3 C must push out B after A B A
        r0 = reads;
        access(1'b0, line_addr(2, 3), '0, '0, cycles);
        access(1'b0, line_addr(3, 3), '0, '0, cycles);
        access(1'b0, line_addr(2, 3), '0, '0, cycles);
        check_count(reads, r0 + 2, "pmem reads after A B A");
        access(1'b0, line_addr(4, 3), '0, '0, cycles);
        access(1'b0, line_addr(2, 3), '0, '0, cycles);
        check_count(reads, r0 + 3, "pmem reads after C and A");
        access(1'b0, line_addr(3, 3), '0, '0, cycles);
        check_count(reads, r0 + 4, "pmem reads after B refetch");
        check_count(writes, 0, "pmem writes with clean lines");

        // dirty D in set 5 evicted by E and F and read back
        w0 = writes;
        random_line(wdata);
        be = $random(seed);
        access(1'b1, line_addr(5, 5), wdata, be, cycles);
        access(1'b0, line_addr(6, 5), '0, '0, cycles);
        access(1'b0, line_addr(7, 5), '0, '0, cycles);
        check_count(writes, w0 + 1, "pmem writes after dirty eviction");
        access(1'b0, line_addr(5, 5), '0, '0, cycles);
        check_count(writes, w0 + 1, "pmem writes after D read back");

        @(negedge clk);
        cpu_req = '0;
        @(negedge clk);
        $display("errors: line %0d, count %0d, protocol %0d", line_errs, count_errs, proto_errs);
        if (line_errs + count_errs + proto_errs == 0)
        begin
            $display("Everything OK");
        end
        else
        begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+.
rv32i_types.sv
cache_array.sv
cache_data_array.sv
cache_datapath.sv
cache_control.sv
cache.sv
tb_mem_model.sv
tb_cache.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_cache
FILELIST  = src.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
